// File: Makefile
TOP = uart_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f all.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: all.f
design/uart_pkg.sv
design/byte_chan_if.sv
design/uart_fifo.sv
design/uart_tx_path.sv
design/uart_rx_path.sv
design/uart_bus_regs.sv
design/uart_top.sv
verif/uart_tb.sv

// File: design/byte_chan_if.sv
`timescale 1ns/100ps
`default_nettype none

// byte channel between the bus block and one serial path.
interface byte_chan_if import uart_pkg::*; ();

  logic  push;   // enqueue strobe.
  logic  pop;    // dequeue strobe, only while not empty.
  byte_t wdata;
  byte_t rdata;  // fifo head.
  logic  empty;
  logic  full;

  modport bus_mp (
    output push,
    output pop,
    output wdata,
    input  rdata,
    input  empty,
    input  full
  );

  modport path_mp (
    input  push,
    input  pop,
    input  wdata,
    output rdata,
    output empty,
    output full
  );

endinterface

`default_nettype wire

// File: design/uart_bus_regs.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bus_regs import uart_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire         adr_i,
  input  wire  [3:0]  sel_i,
  input  wire  word_t dat_i,
  output word_t       dat_o,
  output logic        ack_o,
  byte_chan_if.bus_mp tx_chan,
  byte_chan_if.bus_mp rx_chan
);

  bus_state_e state_q;
  bus_state_e state_d;
  word_t      conf_q;
  word_t      conf_d;
  word_t      result_q;
  word_t      result_d;
  byte_t      rx_byte_q;  // last byte taken from the rx fifo.
  byte_t      rx_byte_d;
  word_t      status;

  // bit 15 fresh byte, bit 13 tx room.
  assign status = {16'h0000, state_q == bus_read3, 1'b0, ~tx_chan.full, 5'h00, rx_byte_q};

  assign dat_o = result_q;
  assign ack_o = (state_q == bus_done);

  assign tx_chan.push  = (state_q == bus_write);
  assign tx_chan.wdata = dat_i[7:0];  // held by the master until ack.

  assign rx_chan.pop   = (state_q == bus_read2);  // fifo seen non-empty in bus_read.

  always_comb begin
    state_d   = state_q;
    conf_d    = conf_q;
    result_d  = result_q;
    rx_byte_d = rx_byte_q;
    case (state_q)
      bus_idle: begin
        if (cyc_i && stb_i) begin
          if (!adr_i) begin
            state_d = we_i ? bus_write : bus_read;
          end else begin
            if (we_i)
              conf_d = dat_i;
            else
              result_d = conf_q;
            state_d = bus_done;
          end
        end
      end
      bus_write: state_d = bus_done;
      bus_read: begin
        if (rx_chan.empty) begin
          result_d = status;
          state_d  = bus_done;
        end else begin
          state_d = bus_read2;
        end
      end
      bus_read2: begin
        rx_byte_d = rx_chan.rdata;  // head captured as it is popped.
        state_d   = bus_read3;
      end
      bus_read3: begin
        result_d = status;
        state_d  = bus_done;
      end
      default: state_d = bus_idle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= bus_idle;
      conf_q    <= '0;
      result_q  <= '0;
      rx_byte_q <= '0;
    end else begin
      state_q   <= state_d;
      conf_q    <= conf_d;
      result_q  <= result_d;
      rx_byte_q <= rx_byte_d;
    end
  end

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: design/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo import uart_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  wire        clk_i,
  input  wire        rst_i,
  input  wire        push_i,
  input  wire        pop_i,
  input  wire byte_t wdata_i,
  output byte_t      rdata_o,
  output logic       empty_o,
  output logic       full_o
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  byte_t            mem_q [fifo_depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // wraps at depth, so depth need not be a power of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_w'(fifo_depth));
  assign do_push = push_i && !full_o;   // dropped when full.
  assign do_pop  = pop_i && !empty_o;
  assign rdata_o = mem_q[rd_ptr_q];     // show-ahead head.

  always_ff @(posedge clk_i) begin
    if (do_push)
      mem_q[wr_ptr_q] <= wdata_i;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= cnt_w'(fifo_depth));

  a_flags_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(empty_o && full_o));

endmodule

`default_nettype wire

// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

  typedef logic [7:0]  byte_t;  // one serial character.
  typedef logic [31:0] word_t;  // bus word, config and result.

  // bus side sequencing, data reads may take the long path.
  typedef enum logic [2:0] {
    bus_idle  = 3'd0,
    bus_write = 3'd1,
    bus_read  = 3'd2,
    bus_read2 = 3'd3,
    bus_read3 = 3'd4,
    bus_done  = 3'd5
  } bus_state_e;

  typedef enum logic [1:0] {
    tx_idle    = 2'd0,
    tx_dequeue = 2'd1,
    tx_start   = 2'd2,
    tx_wait    = 2'd3
  } tx_state_e;

  typedef enum logic [1:0] {
    rx_idle  = 2'd0,
    rx_start = 2'd1,
    rx_data  = 2'd2,
    rx_stop  = 2'd3
  } rx_state_e;

endpackage

`default_nettype wire

// File: design/uart_rx_path.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_path import uart_pkg::*; #(
  parameter int clkfreq    = 50000000,
  parameter int baud       = 9600,
  parameter int fifo_depth = 16
) (
  input  wire          clk_i,
  input  wire          rst_i,
  byte_chan_if.path_mp chan_i,
  input  wire          rx_i
);

  localparam int clks_per_bit = clkfreq / baud;
  localparam int half_bit     = (clks_per_bit > 1) ? clks_per_bit / 2 : 1;
  localparam int div_w        = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  rx_state_e        state_q;
  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [div_w-1:0] div_q;
  logic [2:0]       bit_idx_q;
  logic             half_end;
  logic             bit_end;
  logic             push_q;
  byte_t            shift_q;
  byte_t            fifo_head;
  logic             fifo_empty;
  logic             fifo_full;

  uart_fifo #(.fifo_depth(fifo_depth)) fifo0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push_q),
    .pop_i   (chan_i.pop),
    .wdata_i (shift_q),
    .rdata_o (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  assign chan_i.rdata = fifo_head;
  assign chan_i.empty = fifo_empty;
  assign chan_i.full  = fifo_full;

  assign half_end = (div_q == div_w'(half_bit - 1));
  assign bit_end  = (div_q == div_w'(clks_per_bit - 1));

  // line idles high.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= rx_idle;
      div_q     <= '0;
      bit_idx_q <= '0;
      push_q    <= 1'b0;
    end else begin
      push_q <= 1'b0;
      case (state_q)
        rx_idle: begin
          div_q <= '0;
          if (!rx_sync_q)
            state_q <= rx_start;
        end
        rx_start: begin
          if (half_end) begin
            div_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_sync_q ? rx_idle : rx_data;  // false start.
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            div_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7)
              state_q <= rx_stop;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            div_q   <= '0;
            push_q  <= rx_sync_q;  // only a high stop bit is queued.
            state_q <= rx_idle;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
      endcase
    end
  end

  // sampled at mid-bit, lsb first.
  always_ff @(posedge clk_i) begin
    if (state_q == rx_data && bit_end)
      shift_q <= {rx_sync_q, shift_q[7:1]};
  end

endmodule

`default_nettype wire

// File: design/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top import uart_pkg::*; #(
  parameter int clkfreq    = 50000000,
  parameter int baud       = 9600,
  parameter int fifo_depth = 16
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire         adr_i,
  input  wire  [3:0]  sel_i,
  input  wire  word_t dat_i,
  output word_t       dat_o,
  output logic        ack_o,
  input  wire         rx_i,
  output logic        tx_o,
  input  wire         cts_i,
  output logic        rts_o,
  output logic [1:0]  interrupt_o
);

  byte_chan_if tx_chan ();
  byte_chan_if rx_chan ();

  assign rts_o       = cts_i;  // no flow control.
  assign interrupt_o = 2'b00;

  uart_bus_regs bus0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o),
    .tx_chan (tx_chan),
    .rx_chan (rx_chan)
  );

  uart_tx_path #(.clkfreq(clkfreq), .baud(baud), .fifo_depth(fifo_depth)) tx0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .chan_i (tx_chan),
    .tx_o   (tx_o)
  );

  uart_rx_path #(.clkfreq(clkfreq), .baud(baud), .fifo_depth(fifo_depth)) rx0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .chan_i (rx_chan),
    .rx_i   (rx_i)
  );

endmodule

`default_nettype wire

// File: design/uart_tx_path.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_path import uart_pkg::*; #(
  parameter int clkfreq    = 50000000,
  parameter int baud       = 9600,
  parameter int fifo_depth = 16
) (
  input  wire          clk_i,
  input  wire          rst_i,
  byte_chan_if.path_mp chan_i,
  output logic         tx_o
);

  localparam int clks_per_bit = clkfreq / baud;
  localparam int div_w        = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  tx_state_e        state_q;
  tx_state_e        state_d;
  byte_t            fifo_head;
  byte_t            tx_byte_q;
  logic             fifo_empty;
  logic             fifo_full;
  logic             fifo_pop;
  logic             ser_start;
  logic             ser_busy_q;
  logic [9:0]       shift_q;   // stop, data, start.
  logic [3:0]       bit_cnt_q;
  logic [div_w-1:0] div_q;

  uart_fifo #(.fifo_depth(fifo_depth)) fifo0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (chan_i.push),
    .pop_i   (fifo_pop),
    .wdata_i (chan_i.wdata),
    .rdata_o (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  assign chan_i.empty = fifo_empty;
  assign chan_i.full  = fifo_full;

  assign fifo_pop  = (state_q == tx_dequeue);
  assign ser_start = (state_q == tx_start);
  assign tx_o      = shift_q[0];  // all ones when idle.

  always_comb begin
    state_d = state_q;
    case (state_q)
      tx_idle:    if (!ser_busy_q && !fifo_empty) state_d = tx_dequeue;
      tx_dequeue: state_d = tx_start;
      tx_start:   state_d = tx_wait;
      tx_wait:    if (ser_busy_q) state_d = tx_idle;  // ready is checked in idle.
      default:    state_d = tx_idle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i)
      state_q <= tx_idle;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop)
      tx_byte_q <= fifo_head;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q    <= '1;
      ser_busy_q <= 1'b0;
      bit_cnt_q  <= '0;
      div_q      <= '0;
    end else if (ser_start) begin
      shift_q    <= {1'b1, tx_byte_q, 1'b0};
      ser_busy_q <= 1'b1;
      bit_cnt_q  <= '0;
      div_q      <= '0;
    end else if (ser_busy_q) begin
      if (div_q == div_w'(clks_per_bit - 1)) begin
        div_q   <= '0;
        shift_q <= {1'b1, shift_q[9:1]};  // lsb first.
        if (bit_cnt_q == 4'd9)
          ser_busy_q <= 1'b0;
        else
          bit_cnt_q <= bit_cnt_q + 1'b1;
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    ser_start |-> !ser_busy_q);

endmodule

`default_nettype wire

// File: verif/uart_cases.txt
# name op adr wdata expected mask  (hex; w write, r read once, p poll until match,
# x write a random byte, q poll for the oldest random byte or'ed into expected)
conf_reset    r 1 00000000 00000000 ffffffff
conf_write    w 1 1234abcd 00000000 00000000
conf_read     r 1 00000000 1234abcd ffffffff
empty_read    r 0 00000000 00002000 0000a0ff
loop_fixed_tx w 0 000000a5 00000000 00000000
loop_fixed_rx p 0 00000000 000080a5 000080ff
loop_rnd1_tx  x 0 00000000 00000000 00000000
loop_rnd1_rx  q 0 00000000 00008000 000080ff
loop_rnd2_tx  x 0 00000000 00000000 00000000
loop_rnd2_rx  q 0 00000000 00008000 000080ff
full_tx1      w 0 00000011 00000000 00000000
full_tx2      w 0 00000022 00000000 00000000
full_tx3      w 0 00000033 00000000 00000000
full_tx4      w 0 00000044 00000000 00000000
full_tx5      w 0 00000055 00000000 00000000
full_flag     r 0 00000000 00000000 0000a000
drain_rx1     p 0 00000000 00008011 000080ff
drain_rx2     p 0 00000000 00008022 000080ff
drain_rx3     p 0 00000000 00008033 000080ff
drain_rx4     p 0 00000000 00008044 000080ff
drain_rx5     p 0 00000000 00008055 000080ff
room_back     r 0 00000000 00002055 0000a0ff

// File: verif/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

  localparam int clkfreq    = 800;
  localparam int baud       = 100;
  localparam int frame_clks = 10 * clkfreq / baud;
  localparam int max_polls  = 400;
  localparam int ack_limit  = 16;

  logic       clk_i;
  logic       rst_i;
  logic       cyc_i;
  logic       stb_i;
  logic       we_i;
  logic       adr_i;
  logic [3:0] sel_i;
  word_t      dat_i;
  word_t      dat_o;
  logic       ack_o;
  logic       rx_i;
  logic       tx_o;
  logic       cts_i;
  logic       rts_o;
  logic [1:0] interrupt_o;

  string name_q [$];
  string op_q   [$];
  word_t adr_q  [$];
  word_t data_q [$];
  word_t exp_q  [$];
  word_t mask_q [$];
  byte_t rnd_q  [$];  // random bytes sent, not yet seen back.
  int    seed;
  int    cycles;
  int    cycle_limit;
  int    passed;
  int    failed;
  int    other_errors;
  logic  fixed_bad;

  assign rx_i = tx_o;  // serial loopback.

  uart_top #(.clkfreq(clkfreq), .baud(baud), .fifo_depth(4)) dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .sel_i       (sel_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .rx_i        (rx_i),
    .tx_o        (tx_o),
    .cts_i       (cts_i),
    .rts_o       (rts_o),
    .interrupt_o (interrupt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cts_i = 1'b0;
    forever @(negedge clk_i) cts_i = ~cts_i;
  end

  always @(posedge clk_i) begin
    if (!rst_i && !fixed_bad) begin
      assert (interrupt_o == 2'b00 && rts_o == cts_i) else begin
        $display("Error fixed_outputs: expected rts %b irq 00, actual rts %b irq %b",
                 cts_i, rts_o, interrupt_o);
        fixed_bad = 1'b1;
        other_errors++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    string nm;
    string op;
    word_t adr;
    word_t dat;
    word_t expv;
    word_t msk;
    fd = $fopen("verif/uart_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/uart_cases.txt");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %s %h %h %h %h", nm, op, adr, dat, expv, msk);
      if (n != 6) begin
        $display("malformed line in case file: %s", line);
        other_errors++;
        continue;
      end
      name_q.push_back(nm);
      op_q.push_back(op);
      adr_q.push_back(adr);
      data_q.push_back(dat);
      exp_q.push_back(expv);
      mask_q.push_back(msk);
    end
    $fclose(fd);
  endtask

  // one request, held until ack, then released.
  task automatic bus_access(input logic we, input logic adr, input word_t wdata,
                            output word_t rdata, output logic ok);
    int waited;
    @(negedge clk_i);
    cyc_i  = 1'b1;
    stb_i  = 1'b1;
    we_i   = we;
    adr_i  = adr;
    dat_i  = wdata;
    sel_i  = 4'hf;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!ack_o && waited < ack_limit);
    ok    = ack_o;
    rdata = dat_o;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    assert (ok) else
      $display("no ack_o within %0d cycles of a request", ack_limit);
    @(negedge clk_i);
    assert (!ack_o) else begin
      $display("ack_o stayed high for more than one cycle");
      ok = 1'b0;
    end
  endtask

  task automatic run_case(input int i);
    word_t rd;
    word_t expv;
    word_t wdat;
    logic  ok;
    logic  hit;
    logic  bad;
    int    polls;
    int    tmp;
    bad  = 1'b0;
    expv = exp_q[i];
    wdat = data_q[i];
    if (op_q[i] == "x") begin
      tmp  = $random(seed);
      wdat = {24'h0, tmp[7:0]};
      rnd_q.push_back(tmp[7:0]);
    end
    if (op_q[i] == "q")
      expv = expv | {24'h0, rnd_q.pop_front()};  // oldest byte comes back first.
    if (op_q[i] == "w" || op_q[i] == "x") begin
      bus_access(1'b1, adr_q[i][0], wdat, rd, ok);
      bad = !ok;
    end else begin
      polls = 0;
      do begin
        bus_access(1'b0, adr_q[i][0], 32'h0, rd, ok);
        polls++;
        hit = ((rd & mask_q[i]) == expv) || (mask_q[i][15] && expv[15] && rd[15]);
      end while (ok && op_q[i] != "r" && !hit && polls < max_polls);
      bad = !ok;
      assert (!ok || op_q[i] == "r" || hit) else begin
        $display("%s: no fresh byte after %0d polls", name_q[i], polls);
        bad = 1'b1;
      end
      assert (bad || (rd & mask_q[i]) == expv) else begin
        $display("Error %s: expected %h (mask %h), actual %h", name_q[i], expv,
                 mask_q[i], rd);
        bad = 1'b1;
      end
    end
    if (bad)
      failed++;
    else
      passed++;
    $display("%-14s %s", name_q[i], bad ? "failed" : "ok");
  endtask

  initial begin
    seed         = 63;
    cycles       = 0;
    passed       = 0;
    failed       = 0;
    other_errors = 0;
    fixed_bad    = 1'b0;
    rst_i        = 1'b1;
    cyc_i        = 1'b0;
    stb_i        = 1'b0;
    we_i         = 1'b0;
    adr_i        = 1'b0;
    sel_i        = 4'h0;
    dat_i        = '0;
    load_cases();
    cycle_limit = name_q.size() * 30 * frame_clks;
    if (name_q.size() == 0)
      other_errors++;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    foreach (name_q[i])
      run_case(i);
    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             name_q.size(), passed, failed, other_errors);
    if (failed == 0 && other_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
